// File: Makefile
# Verilator flow for the AHB-Lite CRC calculator

VERILATOR ?= verilator
TOP       ?= crcahb_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/crcahb_tb.sv
// Testbench for the AHB-Lite CRC calculator with bus tasks, reference CRC model and directed tests
`timescale 1ns/1ns
`default_nettype none

module crcahb_tb
	import crc_pkg::*;
();

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 2000;

	logic        HCLK = 1'b0;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	wire  [31:0] HRDATA;
	wire         HREADYOUT;
	wire         HRESP;

	integer      seed;
	// Stimulus vector shared by the burst task and the model
	logic [31:0] vec_data [16];
	logic [1:0]  vec_size [16];
	int          vec_n;
	int          stall_cycles;
	int          burst_stalls;
	logic [31:0] rd_data;

	crcahb_top UUT
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #(CLK_PERIOD / 2) HCLK = ~HCLK;

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		assert (actual === expected)
		else
			report_failure($sformatf("** Error at %0t ns: %s expected %08h, actual %08h",
			                         $time, name, expected, actual));
	endtask

	//////////////////////////////////////////////////
	// AHB-Lite master
	//////////////////////////////////////////////////

	// Address phase of a NONSEQ transfer to one register
	task automatic drive_address(input logic [2:0] reg_sel, input logic write,
	                             input logic [1:0] size);
		HSElx  <= 1'b1;
		HADDR  <= {27'h0, reg_sel, 2'b00};
		HTRANS <= HTRANS_NONSEQ;
		HWRITE <= write;
		HSIZE  <= {1'b0, size};
	endtask

	task automatic drive_idle();
		HSElx  <= 1'b0;
		HTRANS <= HTRANS_IDLE;
		HWRITE <= 1'b0;
	endtask

	// Returns on the first falling edge with HREADYOUT high
	task automatic wait_ready();
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stall_cycles++;
			@(negedge HCLK);
		end
		check_value("HRESP", {31'h0, HRESP_OKAY}, {31'h0, HRESP});
	endtask

	task automatic ahb_write(input logic [2:0] reg_sel, input logic [31:0] data);
		@(posedge HCLK);
		drive_address(reg_sel, 1'b1, 2'd2);
		wait_ready();
		@(posedge HCLK);
		drive_idle();
		HWDATA <= data;
		// Data phase ends on the next rising edge
		wait_ready();
	endtask

	task automatic ahb_read(input logic [2:0] reg_sel, output logic [31:0] data);
		@(posedge HCLK);
		drive_address(reg_sel, 1'b0, 2'd2);
		wait_ready();
		@(posedge HCLK);
		drive_idle();
		wait_ready();
		data = HRDATA;
	endtask

	// Pipelined DR writes where each address overlaps the previous data phase
	task automatic dr_write_burst();
		int i;
		@(posedge HCLK);
		drive_address(CRC_DR, 1'b1, vec_size[0]);
		for (i = 0; i < vec_n; i++)
		begin
			wait_ready();
			@(posedge HCLK);
			HWDATA <= vec_data[i];
			if (i + 1 < vec_n)
				drive_address(CRC_DR, 1'b1, vec_size[i + 1]);
			else
				drive_idle();
		end
		wait_ready();
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] cr_word(input logic [1:0] poly_code, input logic [1:0] rev_in,
	                                        input logic rev_out, input logic restart);
		return {24'h0, rev_out, rev_in, poly_code, 2'b00, restart};
	endfunction

	// Reversal groups never exceed the written size
	function automatic logic [31:0] reflect_input(input logic [31:0] w, input logic [1:0] rev,
	                                              input int nbytes);
		int          g;
		int          i;
		logic [31:0] r;
		g = (rev == REV_BYTE) ? 8 : (rev == REV_HALF) ? 16 : (rev == REV_WORD) ? 32 : 0;
		if (g > 8 * nbytes)
			g = 8 * nbytes;
		if (g == 0)
			return w;
		for (i = 0; i < 32; i++)
			r[(i / g) * g + g - 1 - (i % g)] = w[i];
		return r;
	endfunction

	// Bit-serial CRC over vec_data taking the low byte first and each byte MSB first
	function automatic logic [31:0] crc_model(input logic [1:0] poly_code, input logic [31:0] poly,
	                                          input logic [31:0] init, input logic [1:0] rev_in,
	                                          input logic rev_out);
		int          width;
		int          nbytes;
		int          k;
		int          b;
		int          j;
		logic [31:0] mask;
		logic [31:0] crc;
		logic [31:0] word;
		logic [31:0] outv;
		logic        fb;
		case (poly_code)
			POLY_32: width = 32;
			POLY_16: width = 16;
			POLY_8:  width = 8;
			default: width = 7;
		endcase
		mask = (width == 32) ? 32'hFFFF_FFFF : (32'h1 << width) - 32'h1;
		crc  = init & mask;
		for (k = 0; k < vec_n; k++)
		begin
			nbytes = 1 << vec_size[k];
			word   = reflect_input(vec_data[k], rev_in, nbytes);
			for (b = 0; b < nbytes; b++)
				for (j = 7; j >= 0; j--)
				begin
					fb  = crc[width - 1] ^ word[8 * b + j];
					crc = (crc << 1) & mask;
					if (fb)
						crc = (crc ^ poly) & mask;
				end
		end
		outv = crc;
		if (rev_out)
		begin
			outv = '0;
			for (j = 0; j < width; j++)
				outv[width - 1 - j] = crc[j];
		end
		return outv;
	endfunction

	//////////////////////////////////////////////////
	// Test helpers
	//////////////////////////////////////////////////

	task automatic fill_random(input int n, input bit mixed);
		int i;
		vec_n = n;
		for (i = 0; i < n; i++)
		begin
			vec_data[i] = $random(seed);
			vec_size[i] = mixed ? 2'($unsigned($random(seed)) % 3) : 2'd2;
		end
	endtask

	// Configure, restart, stream vec_data and compare the DR result
	task automatic run_and_check(input string name, input logic [1:0] poly_code,
	                             input logic [31:0] poly, input logic [31:0] init,
	                             input logic [1:0] rev_in, input logic rev_out);
		ahb_write(CRC_POL, poly);
		ahb_write(CRC_INIT, init);
		ahb_write(CRC_CR, cr_word(poly_code, rev_in, rev_out, 1'b1));
		stall_cycles = 0;
		dr_write_burst();
		burst_stalls = stall_cycles;
		ahb_read(CRC_DR, rd_data);
		check_value(name, crc_model(poly_code, poly, init, rev_in, rev_out), rd_data);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic read_reset_values();
		ahb_read(CRC_INIT, rd_data);
		check_value("HRDATA (INIT)", RESET_CRC_INIT, rd_data);
		ahb_read(CRC_POL, rd_data);
		check_value("HRDATA (POL)", RESET_CRC_POLY, rd_data);
		ahb_read(CRC_IDR, rd_data);
		check_value("HRDATA (IDR)", {24'h0, RESET_CRC_IDR}, rd_data);
		ahb_read(CRC_CR, rd_data);
		check_value("HRDATA (CR)", {24'h0, RESET_CRC_CR, 3'b000}, rd_data);
		// Engine starts from the reset initial value
		ahb_read(CRC_DR, rd_data);
		check_value("HRDATA (DR)", RESET_CRC_INIT, rd_data);
	endtask

	task automatic exercise_registers();
		logic [31:0] value;
		// Scratch keeps one byte
		ahb_write(CRC_IDR, 32'h1234_56A7);
		ahb_read(CRC_IDR, rd_data);
		check_value("HRDATA (IDR)", 32'h0000_00A7, rd_data);
		value = $random(seed);
		ahb_write(CRC_INIT, value);
		ahb_read(CRC_INIT, rd_data);
		check_value("HRDATA (INIT)", value, rd_data);
		value = $random(seed);
		ahb_write(CRC_POL, value);
		ahb_read(CRC_POL, rd_data);
		check_value("HRDATA (POL)", value, rd_data);
		// Bits 7:3 are stored in place and bits 2:0 read as zero
		ahb_write(CRC_CR, 32'h5A5A_5AAF);
		ahb_read(CRC_CR, rd_data);
		check_value("HRDATA (CR)", 32'h0000_00A8, rd_data);
	endtask

	task automatic stream_crc32_words();
		fill_random(12, 1'b0);
		run_and_check("HRDATA (DR, CRC-32 stream)", POLY_32, RESET_CRC_POLY, RESET_CRC_INIT,
		              REV_NONE, 1'b0);
		assert (burst_stalls > 0)
		else
			report_failure("HREADYOUT never dropped while back-to-back DR writes filled the buffer");
	endtask

	task automatic mix_sizes_and_widths();
		fill_random(8, 1'b1);
		run_and_check("HRDATA (DR, CRC-16)", POLY_16, 32'h0000_1021, 32'h0000_FFFF, REV_NONE, 1'b0);
		fill_random(8, 1'b1);
		run_and_check("HRDATA (DR, CRC-8)", POLY_8, 32'h0000_0007, 32'h0000_00A5, REV_NONE, 1'b0);
		fill_random(8, 1'b1);
		run_and_check("HRDATA (DR, CRC-7)", POLY_7, 32'h0000_0009, 32'h0000_0000, REV_NONE, 1'b0);
		fill_random(8, 1'b1);
		run_and_check("HRDATA (DR, CRC-32C)", POLY_32, 32'h1EDC_6F41, 32'hFFFF_FFFF, REV_NONE,
		              1'b0);
	endtask

	task automatic sweep_reversal_modes();
		int r;
		int o;
		// Mixed sizes so that group clamping is exercised
		vec_n       = 4;
		vec_data[0] = 32'h1234_5678;
		vec_size[0] = 2'd2;
		vec_data[1] = 32'h0000_A5F0;
		vec_size[1] = 2'd1;
		vec_data[2] = 32'h0000_003C;
		vec_size[2] = 2'd0;
		vec_data[3] = 32'hDEAD_BEEF;
		vec_size[3] = 2'd2;
		for (r = 0; r < 4; r++)
			for (o = 0; o < 2; o++)
			begin
				run_and_check($sformatf("HRDATA (DR, CRC-32 rev_in %0d rev_out %0d)", r, o),
				              POLY_32, RESET_CRC_POLY, RESET_CRC_INIT, 2'(r), 1'(o));
				run_and_check($sformatf("HRDATA (DR, CRC-7 rev_in %0d rev_out %0d)", r, o),
				              POLY_7, 32'h0000_0009, 32'h0000_007F, 2'(r), 1'(o));
			end
	endtask

	task automatic restart_with_new_init();
		logic [31:0] new_init;
		fill_random(3, 1'b0);
		run_and_check("HRDATA (DR, before restart)", POLY_32, RESET_CRC_POLY, RESET_CRC_INIT,
		              REV_NONE, 1'b0);
		new_init = $random(seed);
		ahb_write(CRC_INIT, new_init);
		ahb_write(CRC_CR, cr_word(POLY_32, REV_NONE, 1'b0, 1'b1));
		// Earlier words must not leak into the new result
		fill_random(1, 1'b0);
		dr_write_burst();
		ahb_read(CRC_DR, rd_data);
		check_value("HRDATA (DR, after restart)",
		            crc_model(POLY_32, RESET_CRC_POLY, new_init, REV_NONE, 1'b0), rd_data);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		seed    = 32'h98ca1cdb;
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = HTRANS_IDLE;
		HSIZE   = 3'b010;
		HWRITE  = 1'b0;
		HWDATA  = 32'h0;
		// Single slave whose HREADYOUT is combined with HREADY inside the DUT
		HREADY  = 1'b1;
		stall_cycles = 0;
		repeat (2) @(posedge HCLK);
		HRESETn <= 1'b1;
		read_reset_values();
		exercise_registers();
		stream_crc32_words();
		mix_sizes_and_widths();
		sweep_reversal_modes();
		restart_with_new_init();
		@(posedge HCLK);
		$display("Simulation PASSED");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		report_failure("Timeout: the tests did not complete within the cycle budget");
	end

endmodule

`default_nettype wire

// File: verilog/crc_datapath.sv
// INIT, POL and IDR registers, bit reversal and the byte-serial CRC engine
`timescale 1ns/1ns
`default_nettype none

module crc_datapath
	import crc_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire  [31:0] bus_wr,
	input  wire         crc_init_en,
	input  wire         crc_idr_en,
	input  wire         crc_poly_en,
	input  wire         reset_chain,
	input  wire  [1:0]  crc_poly_size,
	input  wire  [1:0]  rev_in_type,
	input  wire         rev_out_type,
	input  wire  [31:0] buf_data,
	input  wire  [1:0]  buf_size,
	input  wire         buf_empty,
	output logic        buf_pop,
	output logic [31:0] crc_out,
	output logic [31:0] crc_init_out,
	output logic [31:0] crc_poly_out,
	output logic [7:0]  crc_idr_out,
	output logic        reset_pending,
	output logic        read_wait
);

	logic [31:0] crc_init_ff;
	logic [31:0] crc_poly_ff;
	logic [7:0]  crc_idr_ff;
	// Running CRC whose bits above the active width are ignored
	logic [31:0] crc_ff;
	// Remaining bytes of the current word with the next byte at the bottom
	logic [31:0] shift_ff;
	logic [2:0]  byte_cnt;
	logic        busy;
	logic [2:0]  pop_count;
	logic [31:0] pop_word;
	logic [31:0] crc_masked;
	logic [31:0] crc_reflect;
	logic [4:0]  out_shift;

	//////////////////////////////////////////////////
	// Helper functions
	//////////////////////////////////////////////////

	// Keep only the active CRC width
	function automatic logic [31:0] poly_mask(input logic [1:0] size);
		case (size)
			POLY_32: poly_mask = 32'hFFFF_FFFF;
			POLY_16: poly_mask = 32'h0000_FFFF;
			POLY_8:  poly_mask = 32'h0000_00FF;
			POLY_7:  poly_mask = 32'h0000_007F;
		endcase
	endfunction

	// Bit reversal inside groups of m+1 bits for m of 0, 7, 15 or 31
	function automatic logic [31:0] rev_group(input logic [31:0] d, input logic [4:0] m);
		logic [31:0] r;
		int i;
		for (i = 0; i < 32; i++)
			r[i] = d[i ^ int'(m)];
		rev_group = r;
	endfunction

	// Input reversal never crosses the written size
	function automatic logic [4:0] in_rev_mask(input logic [1:0] rev, input logic [1:0] size);
		logic [1:0] limit;
		logic [1:0] eff;
		limit = (size == 2'd0) ? REV_BYTE : (size == 2'd1) ? REV_HALF : REV_WORD;
		eff   = (rev > limit) ? limit : rev;
		case (eff)
			REV_NONE: in_rev_mask = 5'd0;
			REV_BYTE: in_rev_mask = 5'd7;
			REV_HALF: in_rev_mask = 5'd15;
			REV_WORD: in_rev_mask = 5'd31;
		endcase
	endfunction

	// Eight shift-XOR steps with data MSB first and feedback from the top of the active width
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
	                                          input logic [31:0] poly, input logic [1:0] size);
		logic [31:0] c;
		logic        fb;
		int          i;
		c = crc;
		for (i = 7; i >= 0; i--)
		begin
			case (size)
				POLY_32: fb = c[31];
				POLY_16: fb = c[15];
				POLY_8:  fb = c[7];
				POLY_7:  fb = c[6];
			endcase
			fb = fb ^ data[i];
			c  = {c[30:0], 1'b0};
			if (fb)
				c = c ^ poly;
		end
		fold_byte = c & poly_mask(size);
	endfunction

	//////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_ff <= RESET_CRC_INIT;
			crc_poly_ff <= RESET_CRC_POLY;
			crc_idr_ff  <= RESET_CRC_IDR;
		end
		else
		begin
			if (crc_init_en)
				crc_init_ff <= bus_wr;
			if (crc_poly_en)
				crc_poly_ff <= bus_wr;
			// Scratch keeps the low byte only
			if (crc_idr_en)
				crc_idr_ff <= bus_wr[7:0];
		end
	end

	//////////////////////////////////////////////////
	// Byte-serial engine
	//////////////////////////////////////////////////

	assign busy = (byte_cnt != 3'd0);

	// Take a new word only when idle and no restart is due
	assign buf_pop   = !buf_empty && !busy && !reset_pending;
	assign read_wait = !buf_empty || busy || reset_pending;

	// Bytes per word from the transfer size
	assign pop_count = (buf_size == 2'd0) ? 3'd1 : (buf_size == 2'd1) ? 3'd2 : 3'd4;
	assign pop_word  = rev_group(buf_data, in_rev_mask(rev_in_type, buf_size));

	// Restart has priority and stalls any fold in progress for one cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_ff        <= RESET_CRC_INIT;
			byte_cnt      <= 3'd0;
			reset_pending <= 1'b0;
		end
		else
		begin
			reset_pending <= reset_chain;
			if (reset_pending)
				crc_ff <= crc_init_ff;
			else if (busy)
			begin
				crc_ff   <= fold_byte(crc_ff, shift_ff[7:0], crc_poly_ff, crc_poly_size);
				byte_cnt <= byte_cnt - 3'd1;
			end
			else if (buf_pop)
				byte_cnt <= pop_count;
		end
	end

	// Word shifter that hands out the least significant byte first
	always_ff @(posedge HCLK)
	begin
		if (buf_pop)
			shift_ff <= pop_word;
		else if (busy && !reset_pending)
			shift_ff <= {8'h00, shift_ff[31:8]};
	end

	// Output view is optionally reflected within the active width
	assign crc_masked  = crc_ff & poly_mask(crc_poly_size);
	assign out_shift   = (crc_poly_size == POLY_32) ? 5'd0  :
	                     (crc_poly_size == POLY_16) ? 5'd16 :
	                     (crc_poly_size == POLY_8)  ? 5'd24 : 5'd25;
	assign crc_reflect = rev_group(crc_masked, 5'd31) >> out_shift;

	assign crc_out      = rev_out_type ? crc_reflect : crc_masked;
	assign crc_init_out = crc_init_ff;
	assign crc_poly_out = crc_poly_ff;
	assign crc_idr_out  = crc_idr_ff;

	// Only byte, halfword and word transfers reach the engine
	a_pop_size: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_pop |-> (buf_size != 2'd3));

	// INIT stays unchanged in the cycle that restart loads it
	a_init_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_pending |-> !crc_init_en);

endmodule

`default_nettype wire

// File: verilog/crc_host_interface.sv
// AHB-Lite slave with address pipeline, register decode, control register, read mux and wait states
`timescale 1ns/1ns
`default_nettype none

module crc_host_interface
	import crc_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         HSElx,
	input  wire  [31:0] HADDR,
	input  wire  [1:0]  HTRANS,
	input  wire  [2:0]  HSIZE,
	input  wire         HWRITE,
	input  wire  [31:0] HWDATA,
	input  wire         HREADY,
	input  wire  [31:0] crc_out,
	input  wire  [31:0] crc_init_out,
	input  wire  [31:0] crc_poly_out,
	input  wire  [7:0]  crc_idr_out,
	input  wire         buffer_full,
	input  wire         reset_pending,
	input  wire         read_wait,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	output logic [31:0] bus_wr,
	output logic [1:0]  bus_size,
	output logic        buffer_write_en,
	output logic        crc_init_en,
	output logic        crc_idr_en,
	output logic        crc_poly_en,
	output logic        reset_chain,
	output logic [1:0]  crc_poly_size,
	output logic [1:0]  rev_in_type,
	output logic        rev_out_type
);

	// Address phase copy
	logic [2:0]  haddr_pp;
	logic [1:0]  hsize_pp;
	logic [1:0]  htrans_pp;
	logic        hwrite_pp;
	logic        hselx_pp;

	// Stored CR fields {rev_out, rev_in, poly_size}
	logic [4:0]  crc_cr_ff;

	logic        sample_bus;
	logic        transfer_active;
	logic        write_en;
	logic        read_en;
	logic        crc_dr_sel;
	logic        crc_idr_sel;
	logic        crc_cr_sel;
	logic        crc_init_sel;
	logic        crc_poly_sel;
	logic        dr_wr;
	logic        dr_rd;
	logic        init_wr;
	logic        crc_cr_en;
	logic [31:0] crc_cr_rd;

	//////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////

	// Bus sampled only when every slave is ready
	assign sample_bus = HREADY && HREADYOUT;

	// Control part of the address phase
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= HTRANS_IDLE;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Address and size are held through wait states
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	// Only NONSEQ starts a register access
	assign transfer_active = hselx_pp && (htrans_pp == HTRANS_NONSEQ);
	assign write_en        = transfer_active && hwrite_pp;
	assign read_en         = transfer_active && !hwrite_pp;

	// Register selects
	assign crc_dr_sel   = (haddr_pp == CRC_DR);
	assign crc_idr_sel  = (haddr_pp == CRC_IDR);
	assign crc_cr_sel   = (haddr_pp == CRC_CR);
	assign crc_init_sel = (haddr_pp == CRC_INIT);
	assign crc_poly_sel = (haddr_pp == CRC_POL);

	assign dr_wr   = crc_dr_sel && write_en;
	assign dr_rd   = crc_dr_sel && read_en;
	assign init_wr = crc_init_sel && write_en;

	// DR and INIT write strobes are held back until the datapath can take them
	assign buffer_write_en = dr_wr && !buffer_full;
	assign crc_init_en     = init_wr && !reset_pending;
	assign crc_idr_en      = crc_idr_sel && write_en;
	assign crc_poly_en     = crc_poly_sel && write_en;
	assign crc_cr_en       = crc_cr_sel && write_en;

	// Write data is taken straight from the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Stretch the data phase on full buffer, pending DR read or pending restart
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));
	assign HRESP = HRESP_OKAY;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////

	// CR bits 7:3 are stored and bit 0 is only a strobe
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= RESET_CRC_CR;
		else if (crc_cr_en)
			crc_cr_ff <= HWDATA[7:3];
	end

	assign reset_chain   = crc_cr_en && HWDATA[0];
	assign crc_poly_size = crc_cr_ff[1:0];
	assign rev_in_type   = crc_cr_ff[3:2];
	assign rev_out_type  = crc_cr_ff[4];

	// CR read view with bit 0 always zero
	assign crc_cr_rd = {24'h0, crc_cr_ff, 3'b000};

	// One-hot AND-OR read mux
	assign HRDATA = ({32{crc_dr_sel}}   & crc_out)              |
	                ({32{crc_idr_sel}}  & {24'h0, crc_idr_out}) |
	                ({32{crc_cr_sel}}   & crc_cr_rd)            |
	                ({32{crc_init_sel}} & crc_init_out)         |
	                ({32{crc_poly_sel}} & crc_poly_out);

	// Master holds write data while the data phase is stretched
	a_wdata_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		write_en && !HREADYOUT |=> $stable(HWDATA));

	// An INIT write waits for at most the one restart cycle
	a_init_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
		init_wr && reset_pending |=> !reset_pending);

endmodule

`default_nettype wire

// File: verilog/crc_input_buffer.sv
// Circular FIFO of data words and transfer sizes between the bus and the CRC engine
`timescale 1ns/1ns
`default_nettype none

module crc_input_buffer
	import crc_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire  [31:0] bus_wr,
	input  wire  [1:0]  bus_size,
	input  wire         buffer_write_en,
	input  wire         buf_pop,
	output logic        buffer_full,
	output logic        buf_empty,
	output logic [31:0] buf_data,
	output logic [1:0]  buf_size
);

	// Entry storage
	logic [31:0]       data_mem [BUF_DEPTH];
	logic [1:0]        size_mem [BUF_DEPTH];

	// Pointers wrap on their own since the depth is a power of two
	logic [BUF_AW-1:0] wr_ptr;
	logic [BUF_AW-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers
	logic [BUF_AW:0]   count;

	// Store the word and its size at the tail
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			data_mem[wr_ptr] <= bus_wr;
			size_mem[wr_ptr] <= bus_size;
		end
	end

	// Pointer and occupancy update
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (buffer_write_en)
				wr_ptr <= wr_ptr + BUF_AW'(1);
			if (buf_pop)
				rd_ptr <= rd_ptr + BUF_AW'(1);
			case ({buffer_write_en, buf_pop})
				2'b10:   count <= count + (BUF_AW+1)'(1);
				2'b01:   count <= count - (BUF_AW+1)'(1);
				default: count <= count;
			endcase
		end
	end

	// Head of queue
	assign buf_data    = data_mem[rd_ptr];
	assign buf_size    = size_mem[rd_ptr];
	assign buf_empty   = (count == '0);
	assign buffer_full = (count == (BUF_AW+1)'(BUF_DEPTH));

	// Host interface must hold off writes while full
	a_no_overflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

	// Engine must only pop a valid head
	a_no_underflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_pop |-> !buf_empty);

endmodule

`default_nettype wire

// File: verilog/crc_pkg.sv
// Register offsets, AHB encodings, reset values, CRC width and reversal codes, buffer sizing
`default_nettype none

package crc_pkg;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Word offsets from HADDR[4:2]
	localparam logic [2:0] CRC_DR   = 3'h0;
	localparam logic [2:0] CRC_IDR  = 3'h1;
	localparam logic [2:0] CRC_CR   = 3'h2;
	localparam logic [2:0] CRC_INIT = 3'h4;
	localparam logic [2:0] CRC_POL  = 3'h5;

	//////////////////////////////////////////////////
	// AHB-Lite encodings
	//////////////////////////////////////////////////

	// HTRANS
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// HRESP, only OKAY is ever returned
	localparam logic HRESP_OKAY = 1'b0;

	//////////////////////////////////////////////////
	// Reset values
	//////////////////////////////////////////////////

	// CR fields {rev_out, rev_in[1:0], poly_size[1:0]}
	localparam logic [4:0]  RESET_CRC_CR   = 5'h00;
	localparam logic [31:0] RESET_CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_CRC_POLY = 32'h04C1_1DB7;
	localparam logic [7:0]  RESET_CRC_IDR  = 8'h00;

	// Polynomial width codes
	localparam logic [1:0] POLY_32 = 2'd0;
	localparam logic [1:0] POLY_16 = 2'd1;
	localparam logic [1:0] POLY_8  = 2'd2;
	localparam logic [1:0] POLY_7  = 2'd3;

	// Input bit reversal granularity
	localparam logic [1:0] REV_NONE = 2'd0;
	localparam logic [1:0] REV_BYTE = 2'd1;
	localparam logic [1:0] REV_HALF = 2'd2;
	localparam logic [1:0] REV_WORD = 2'd3;

	// Input buffer entries, power of two (2, 4 or 8)
	localparam int BUF_DEPTH = 2;
	// Pointer width
	localparam int BUF_AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

endpackage

`default_nettype wire

// File: verilog/crcahb_top.sv
// CRC calculator top level with host interface, input buffer and datapath
`timescale 1ns/1ns
`default_nettype none

module crcahb_top
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         HSElx,
	input  wire  [31:0] HADDR,
	input  wire  [1:0]  HTRANS,
	input  wire  [2:0]  HSIZE,
	input  wire         HWRITE,
	input  wire  [31:0] HWDATA,
	input  wire         HREADY,
	output wire  [31:0] HRDATA,
	output wire         HREADYOUT,
	output wire         HRESP
);

	// Host interface to buffer and datapath
	wire [31:0] bus_wr;
	wire [1:0]  bus_size;
	wire        buffer_write_en;
	wire        crc_init_en;
	wire        crc_idr_en;
	wire        crc_poly_en;
	wire        reset_chain;
	wire [1:0]  crc_poly_size;
	wire [1:0]  rev_in_type;
	wire        rev_out_type;

	// Buffer status and head word
	wire        buffer_full;
	wire        buf_empty;
	wire [31:0] buf_data;
	wire [1:0]  buf_size;
	wire        buf_pop;

	// Datapath read-back and status
	wire [31:0] crc_out;
	wire [31:0] crc_init_out;
	wire [31:0] crc_poly_out;
	wire [7:0]  crc_idr_out;
	wire        reset_pending;
	wire        read_wait;

	crc_host_interface u_host (.*);

	crc_input_buffer u_buffer (.*);

	crc_datapath u_datapath (.*);

endmodule

`default_nettype wire

// File: vlog.f
verilog/crc_pkg.sv
verilog/crc_host_interface.sv
verilog/crc_input_buffer.sv
verilog/crc_datapath.sv
verilog/crcahb_top.sv
tb/crcahb_tb.sv
